// File: logic/regbank_pkg.sv
package regbank_pkg;

  localparam int DATA_W = 16; // width of one register
  localparam int ADDR_W = 8;  // processor byte address
  localparam int IDX_W  = 6;  // register index, byte address over four

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [IDX_W-1:0]  idx_t;

  // response codes as seen on the write response and read data channels
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } aw_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } w_t;

  typedef struct packed {
    logic  valid;
    resp_t resp;
  } b_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } ar_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    resp_t resp;
  } r_t;

  // a decoded processor write, already checked against the register map
  typedef struct packed {
    logic  en;
    idx_t  idx;
    data_t data;
  } wr_cmd_t;

endpackage

// File: logic/cpu_write_port.sv
module cpu_write_port import regbank_pkg::*; #(
  parameter int unsigned REG_COUNT = 16
) (
  input  logic    clk,
  input  logic    rst_n,
  input  aw_t     aw,
  output logic    aw_ready,
  input  w_t      w,
  output logic    w_ready,
  output b_t      b,
  input  logic    b_ready,
  output wr_cmd_t wr_cmd
);

  // registers below this index hold identity constants
  localparam int unsigned FIRST_WRITABLE = 2;

  logic  aw_held;   // an address has been accepted and waits for its data
  logic  w_held;    // data has been accepted and waits for its address
  addr_t aw_addr_q;
  data_t w_data_q;
  logic  both_held;
  logic  b_valid;
  resp_t b_resp;

  idx_t  wr_idx;
  logic  aligned;
  logic  in_range;
  logic  writable;

  // new beats are refused while a response waits for the master
  assign aw_ready = !aw_held && !b_valid;
  assign w_ready  = !w_held && !b_valid;

  assign both_held = aw_held && w_held;

  assign wr_idx   = aw_addr_q[ADDR_W-1:2];
  assign aligned  = aw_addr_q[1:0] == 2'b00;
  assign in_range = 32'(wr_idx) < REG_COUNT;
  assign writable = aligned && in_range && 32'(wr_idx) >= FIRST_WRITABLE;

  // the command is live for the single cycle in which both halves are present
  assign wr_cmd = '{en: both_held && writable, idx: wr_idx, data: w_data_q};

  assign b = '{valid: b_valid, resp: b_resp};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (aw.valid && aw_ready) begin
        aw_held <= 1'b1;
      end
      if (w.valid && w_ready) begin
        w_held <= 1'b1;
      end
      if (both_held) begin
        // the write commits at this edge and the response goes out with it
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        b_valid <= 1'b1;
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw.valid && aw_ready) begin
      aw_addr_q <= aw.addr;
    end
    if (w.valid && w_ready) begin
      w_data_q <= w.data;
    end
    if (both_held) begin
      b_resp <= writable ? resp_okay : resp_slverr; // misaligned, out of range or identity
    end
  end

  // the master may sample b on any cycle until it accepts it
  a_b_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    b.valid && !b_ready |=> $stable(b)
  );

  // a second write must not reach the store before the first one is acknowledged
  a_one_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_cmd.en |-> !b.valid
  );

endmodule

// File: logic/cpu_read_port.sv
module cpu_read_port import regbank_pkg::*; #(
  parameter int unsigned REG_COUNT = 16
) (
  input  logic  clk,
  input  logic  rst_n,
  input  ar_t   ar,
  output logic  ar_ready,
  output r_t    r,
  input  logic  r_ready,
  input  data_t regs [REG_COUNT]
);

  idx_t  ar_idx;
  logic  ar_ok;
  logic  rd_pend;   // address taken, data is sampled at the next edge
  idx_t  rd_idx_q;
  logic  rd_ok_q;
  data_t sel_val;
  logic  r_valid;
  data_t r_data;
  resp_t r_resp;

  assign ar_idx   = ar.addr[ADDR_W-1:2];
  assign ar_ok    = ar.addr[1:0] == 2'b00 && 32'(ar_idx) < REG_COUNT;
  assign ar_ready = !r_valid && !rd_pend; // one read in flight at a time

  // register mux, a bad address selects zero
  always_comb begin
    sel_val = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      if (rd_ok_q && rd_idx_q == idx_t'(i)) begin
        sel_val = regs[i];
      end
    end
  end

  assign r = '{valid: r_valid, data: r_data, resp: r_resp};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      rd_pend <= ar.valid && ar_ready;
      if (rd_pend) begin
        r_valid <= 1'b1;
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // sampling one cycle late picks up a write committed on the accepting edge
  always_ff @(posedge clk) begin
    if (ar.valid && ar_ready) begin
      rd_idx_q <= ar_idx;
      rd_ok_q  <= ar_ok;
    end
    if (rd_pend) begin
      r_data <= sel_val;
      r_resp <= rd_ok_q ? resp_okay : resp_slverr;
    end
  end

  a_r_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    r.valid && !r_ready |=> $stable(r)
  );

endmodule

// File: logic/reg_store.sv
module reg_store import regbank_pkg::*; #(
  parameter int unsigned REG_COUNT   = 16,
  parameter data_t       BURST_LIMIT = 16'd8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  wr_cmd_t              wr_cmd,
  input  logic [REG_COUNT-1:0] fab_wr_stb,
  input  data_t                fab_wr_data [REG_COUNT],
  input  logic [REG_COUNT-1:0] fab_rd_stb,
  output data_t                fab_rd_data [REG_COUNT],
  output logic [REG_COUNT-1:0] fresh,
  output data_t                regs [REG_COUNT]
);

  // register 0 reports the register count, register 1 the burst limit
  localparam int unsigned READ_ONLY_REGS = 2;

  for (genvar i = 0; i < REG_COUNT; i++) begin : g_reg

    if (i < READ_ONLY_REGS) begin : g_id
      // identity registers are constants, fabric writes to them go nowhere
      if (i == 0) begin : g_count
        assign regs[i] = data_t'(REG_COUNT);
      end else begin : g_limit
        assign regs[i] = BURST_LIMIT;
      end
      assign fresh[i] = 1'b0; // the processor never commits here

    end else begin : g_rw
      logic  cpu_hit;
      data_t value;
      logic  fresh_q;

      assign cpu_hit = wr_cmd.en && wr_cmd.idx == idx_t'(i);

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          value <= '0;
        end else if (cpu_hit) begin
          value <= wr_cmd.data; // processor wins a same-edge collision
        end else if (fab_wr_stb[i]) begin
          value <= fab_wr_data[i];
        end
      end

      // set by a processor commit, cleared once the fabric has read the value
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          fresh_q <= 1'b0;
        end else if (cpu_hit) begin
          fresh_q <= 1'b1;
        end else if (fab_rd_stb[i]) begin
          fresh_q <= 1'b0;
        end
      end

      assign regs[i]  = value;
      assign fresh[i] = fresh_q;
    end

    // fabric read sees the value from before the edge, so a same-edge write is missed
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        fab_rd_data[i] <= '0;
      end else if (fab_rd_stb[i]) begin
        fab_rd_data[i] <= regs[i];
      end
    end

  end

  // the write port has to filter identity and unmapped indices before they get here
  a_rw_target: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_cmd.en |-> 32'(wr_cmd.idx) >= READ_ONLY_REGS && 32'(wr_cmd.idx) < REG_COUNT
  );

endmodule

// File: logic/regbank_top.sv
module regbank_top import regbank_pkg::*; #(
  parameter int unsigned REG_COUNT   = 16,
  parameter data_t       BURST_LIMIT = 16'd8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  aw_t                  aw,
  output logic                 aw_ready,
  input  w_t                   w,
  output logic                 w_ready,
  output b_t                   b,
  input  logic                 b_ready,
  input  ar_t                  ar,
  output logic                 ar_ready,
  output r_t                   r,
  input  logic                 r_ready,
  input  logic [REG_COUNT-1:0] fab_wr_stb,
  input  data_t                fab_wr_data [REG_COUNT],
  input  logic [REG_COUNT-1:0] fab_rd_stb,
  output data_t                fab_rd_data [REG_COUNT],
  output logic [REG_COUNT-1:0] fresh
);

  wr_cmd_t wr_cmd;            // decoded processor write into the store
  data_t   regs [REG_COUNT];  // live register values for the read mux

  cpu_write_port #(
    .REG_COUNT (REG_COUNT)
  ) u_cpu_write_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w        (w),
    .w_ready  (w_ready),
    .b        (b),
    .b_ready  (b_ready),
    .wr_cmd   (wr_cmd)
  );

  cpu_read_port #(
    .REG_COUNT (REG_COUNT)
  ) u_cpu_read_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r        (r),
    .r_ready  (r_ready),
    .regs     (regs)
  );

  reg_store #(
    .REG_COUNT   (REG_COUNT),
    .BURST_LIMIT (BURST_LIMIT)
  ) u_reg_store (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_cmd      (wr_cmd),
    .fab_wr_stb  (fab_wr_stb),
    .fab_wr_data (fab_wr_data),
    .fab_rd_stb  (fab_rd_stb),
    .fab_rd_data (fab_rd_data),
    .fresh       (fresh),
    .regs        (regs)
  );

endmodule

// File: bench/regbank_tests.svh
task automatic read_and_check(input addr_t addr, input int hold, input data_t exp_data,
                              input resp_t exp_resp);
  data_t got;
  resp_t resp;
  cpu_read(addr, hold, got, resp);
  check_val($sformatf("read data at %h", addr), 32'(exp_data), 32'(got));
  check_val($sformatf("read resp at %h", addr), 32'(exp_resp), 32'(resp));
endtask

task automatic write_and_check(input addr_t addr, input data_t data, input int aw_gap,
                               input int w_gap, input int hold, input resp_t exp_resp);
  resp_t resp;
  cpu_write(addr, data, aw_gap, w_gap, hold, resp);
  check_val($sformatf("write resp at %h", addr), 32'(exp_resp), 32'(resp));
endtask

task automatic reset_state();
  cur_test = "after_reset";
  check_val("aw_ready", 32'd1, 32'(aw_ready));
  check_val("w_ready", 32'd1, 32'(w_ready));
  check_val("ar_ready", 32'd1, 32'(ar_ready));
  check_val("b.valid", 32'd0, 32'(b.valid));
  check_val("r.valid", 32'd0, 32'(r.valid));
  check_val("fresh", 32'd0, 32'(fresh));
  for (int i = 0; i < REG_COUNT; i++) begin
    check_val($sformatf("fab_rd_data[%0d]", i), 32'd0, 32'(fab_rd_data[i]));
  end
endtask

task automatic identity_regs();
  cur_test = "identity";
  read_and_check(8'h00, 0, shadow[0], resp_okay);
  read_and_check(8'h04, 1, shadow[1], resp_okay);
  // identity registers, an index past the map and a misaligned address all refuse
  write_and_check(8'h00, 16'h1234, 0, 0, 0, resp_slverr);
  write_and_check(8'h04, 16'h5678, 1, 0, 0, resp_slverr);
  write_and_check(addr_t'(REG_COUNT * 4), 16'h9abc, 0, 2, 1, resp_slverr);
  write_and_check(8'h09, 16'hbeef, 0, 0, 0, resp_slverr);
  read_and_check(8'h00, 0, shadow[0], resp_okay);
  read_and_check(8'h04, 0, shadow[1], resp_okay);
  read_and_check(8'h08, 0, shadow[2], resp_okay); // the misaligned write went nowhere
  read_and_check(addr_t'(REG_COUNT * 4), 0, 16'h0000, resp_slverr);
  read_and_check(8'h0a, 0, 16'h0000, resp_slverr);
endtask

task automatic write_read_back();
  data_t val;
  int    aw_gap;
  int    w_gap;
  cur_test = "write_read";
  for (int i = 2; i < REG_COUNT; i++) begin
    val = data_t'(next_rand());
    case (i % 3)
      0: begin
        aw_gap = 0;
        w_gap = 0;
      end
      1: begin
        aw_gap = 0; // address leads
        w_gap = 1 + int'(next_rand() & 32'h3);
      end
      default: begin
        aw_gap = 1 + int'(next_rand() & 32'h3);
        w_gap = 0;
      end
    endcase
    write_and_check(addr_t'(i * 4), val, aw_gap, w_gap, int'(next_rand() & 32'h7), resp_okay);
    shadow[i] = val;
  end
  for (int i = 2; i < REG_COUNT; i++) begin
    read_and_check(addr_t'(i * 4), int'(next_rand() & 32'h7), shadow[i], resp_okay);
  end
endtask

task automatic fresh_flags();
  logic [REG_COUNT-1:0] mask;
  data_t                val;
  data_t                got;
  cur_test = "fresh";
  mask = '0;
  for (int i = 2; i < REG_COUNT; i++) begin
    mask[i] = 1'b1;
  end
  check_val("fresh after writes", 32'(mask), 32'(fresh));
  fab_rd_stb = '1;
  @(negedge clk);
  fab_rd_stb = '0;
  check_val("fresh after fabric reads", 32'd0, 32'(fresh));

  val = data_t'(next_rand());
  write_and_check(8'h14, val, 0, 0, 0, resp_okay);
  shadow[5] = val;
  mask = '0;
  mask[5] = 1'b1;
  check_val("fresh after one write", 32'(mask), 32'(fresh));
  fabric_read(5, got);
  check_val("fab_rd_data[5]", 32'(shadow[5]), 32'(got));
  check_val("fresh after fabric read", 32'd0, 32'(fresh));

  val = data_t'(next_rand());
  fabric_write(7, val);
  shadow[7] = val;
  check_val("fresh after fabric write", 32'd0, 32'(fresh));
  read_and_check(8'h1c, 2, shadow[7], resp_okay);
  fabric_write(0, 16'hffff); // identity registers ignore the fabric
  fabric_write(1, 16'hffff);
  read_and_check(8'h00, 0, shadow[0], resp_okay);
  read_and_check(8'h04, 0, shadow[1], resp_okay);
endtask

task automatic same_edge_rules();
  data_t cpu_val;
  data_t fab_val;
  data_t got;
  resp_t resp;
  int    cyc;
  cur_test = "same_edge";
  cpu_val = data_t'(next_rand());
  fab_val = ~cpu_val;
  aw.valid = 1'b1;
  aw.addr = 8'h18;
  w.valid = 1'b1;
  w.data = cpu_val;
  cyc = 0;
  while (!(aw_ready && w_ready)) begin
    if (cyc > TIMEOUT) begin
      fail_now($sformatf("%s: the write channels never opened", cur_test));
    end
    @(negedge clk);
    cyc++;
  end
  @(negedge clk);
  aw.valid = 1'b0;
  w.valid = 1'b0;
  // both halves are held now and the coming edge commits the processor write
  fab_wr_stb[6] = 1'b1;
  fab_wr_data[6] = fab_val;
  @(negedge clk);
  fab_wr_stb[6] = 1'b0;
  take_b(0, resp);
  check_val("collision write resp", 32'(resp_okay), 32'(resp));
  shadow[6] = cpu_val;
  check_val("fresh after collision", 32'h0000_0040, 32'(fresh));
  read_and_check(8'h18, 0, shadow[6], resp_okay);

  fab_val = ~shadow[9];
  fab_wr_stb[9] = 1'b1;
  fab_wr_data[9] = fab_val;
  fab_rd_stb[9] = 1'b1;
  @(negedge clk);
  fab_wr_stb[9] = 1'b0;
  fab_rd_stb[9] = 1'b0;
  check_val("fab_rd_data[9] on the write edge", 32'(shadow[9]), 32'(fab_rd_data[9]));
  shadow[9] = fab_val;
  fabric_read(9, got);
  check_val("fab_rd_data[9] one edge later", 32'(shadow[9]), 32'(got));
endtask

// File: bench/tb_regbank.sv
module tb_regbank import regbank_pkg::*; ();

  localparam int    REG_COUNT   = 16;
  localparam data_t BURST_LIMIT = 16'd8;
  localparam int    TIMEOUT     = 100; // longest any single wait may take in cycles

  logic                 clk;
  logic                 rst_n;
  aw_t                  aw;
  logic                 aw_ready;
  w_t                   w;
  logic                 w_ready;
  b_t                   b;
  logic                 b_ready;
  ar_t                  ar;
  logic                 ar_ready;
  r_t                   r;
  logic                 r_ready;
  logic [REG_COUNT-1:0] fab_wr_stb;
  data_t                fab_wr_data [REG_COUNT];
  logic [REG_COUNT-1:0] fab_rd_stb;
  data_t                fab_rd_data [REG_COUNT];
  logic [REG_COUNT-1:0] fresh;

  data_t       shadow [REG_COUNT]; // what each register should hold by now
  logic [31:0] rng_state;
  string       cur_test;

  regbank_top #(
    .REG_COUNT   (REG_COUNT),
    .BURST_LIMIT (BURST_LIMIT)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_now($sformatf("error %s %s: expected %h, actual %h", cur_test, what, exp, act));
    end
  endtask

  // waits for the write response, stalls it for hold cycles and then takes it
  task automatic take_b(input int hold, output resp_t resp);
    int cyc;
    cyc = 0;
    while (!b.valid) begin
      if (cyc > TIMEOUT) begin
        fail_now($sformatf("%s: the write response never arrived", cur_test));
      end
      @(negedge clk);
      cyc++;
    end
    repeat (hold) begin
      @(negedge clk);
      check_val("b.valid while stalled", 32'd1, 32'(b.valid));
      check_val("aw_ready while stalled", 32'd0, 32'(aw_ready));
      check_val("w_ready while stalled", 32'd0, 32'(w_ready));
    end
    resp = b.resp;
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic take_r(input int hold, output data_t data, output resp_t resp);
    int cyc;
    cyc = 0;
    while (!r.valid) begin
      if (cyc > TIMEOUT) begin
        fail_now($sformatf("%s: the read data never arrived", cur_test));
      end
      @(negedge clk);
      cyc++;
    end
    repeat (hold) begin
      @(negedge clk);
      check_val("r.valid while stalled", 32'd1, 32'(r.valid));
      check_val("ar_ready while stalled", 32'd0, 32'(ar_ready));
    end
    data = r.data;
    resp = r.resp;
    r_ready = 1'b1;
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  // each channel raises its valid after its own gap, so either may go first
  task automatic cpu_write(input addr_t addr, input data_t data, input int aw_gap,
                           input int w_gap, input int hold, output resp_t resp);
    int   cyc;
    logic aw_done;
    logic w_done;
    logic aw_fire;
    logic w_fire;
    cyc = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    while (!(aw_done && w_done)) begin
      if (cyc > TIMEOUT) begin
        fail_now($sformatf("%s: write address or data was never accepted", cur_test));
      end
      if (!aw_done && cyc >= aw_gap) begin
        aw.valid = 1'b1;
        aw.addr = addr;
      end
      if (!w_done && cyc >= w_gap) begin
        w.valid = 1'b1;
        w.data = data;
      end
      aw_fire = aw.valid && aw_ready; // transfers at the coming rising edge
      w_fire = w.valid && w_ready;
      @(negedge clk);
      if (aw_fire) begin
        aw_done = 1'b1;
        aw.valid = 1'b0;
      end
      if (w_fire) begin
        w_done = 1'b1;
        w.valid = 1'b0;
      end
      cyc++;
    end
    take_b(hold, resp);
  endtask

  task automatic cpu_read(input addr_t addr, input int hold, output data_t data,
                          output resp_t resp);
    int cyc;
    cyc = 0;
    ar.valid = 1'b1;
    ar.addr = addr;
    while (!ar_ready) begin
      if (cyc > TIMEOUT) begin
        fail_now($sformatf("%s: the read address was never accepted", cur_test));
      end
      @(negedge clk);
      cyc++;
    end
    @(negedge clk);
    ar.valid = 1'b0;
    take_r(hold, data, resp);
  endtask

  task automatic fabric_read(input int idx, output data_t data);
    fab_rd_stb[idx] = 1'b1;
    @(negedge clk);
    fab_rd_stb[idx] = 1'b0;
    data = fab_rd_data[idx];
  endtask

  task automatic fabric_write(input int idx, input data_t data);
    fab_wr_stb[idx] = 1'b1;
    fab_wr_data[idx] = data;
    @(negedge clk);
    fab_wr_stb[idx] = 1'b0;
  endtask

  `include "regbank_tests.svh"

  initial begin
    rng_state = 32'hba9b_d9c2;
    cur_test = "reset";
    rst_n = 1'b0;
    aw = '0;
    w = '0;
    ar = '0;
    b_ready = 1'b0;
    r_ready = 1'b0;
    fab_wr_stb = '0;
    fab_rd_stb = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      fab_wr_data[i] = '0;
      shadow[i] = '0;
    end
    shadow[0] = data_t'(REG_COUNT); // identity registers
    shadow[1] = BURST_LIMIT;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    reset_state();
    identity_regs();
    write_read_back();
    fresh_flags();
    same_edge_rules();

    $display("Verification passed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
logic/regbank_pkg.sv
logic/cpu_write_port.sv
logic/cpu_read_port.sv
logic/reg_store.sv
logic/regbank_top.sv
bench/tb_regbank.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_regbank
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# the pass line in the log decides the result
run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
